// ==== csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_XLEN            32
`define CSR_ADDR_W          12

// Machine trap setup and handling
`define CSR_MSTATUS         12'h300
`define CSR_MISA            12'h301
`define CSR_MIE             12'h304
`define CSR_MTVEC           12'h305
`define CSR_MSCRATCH        12'h340
`define CSR_MEPC            12'h341
`define CSR_MCAUSE          12'h342
`define CSR_MTVAL           12'h343
`define CSR_MIP             12'h344

// Counters and their user-level aliases
`define CSR_MCYCLE          12'hB00
`define CSR_MINSTRET        12'hB02
`define CSR_MCYCLEH         12'hB80
`define CSR_MINSTRETH       12'hB82
`define CSR_CYCLE           12'hC00
`define CSR_INSTRET         12'hC02
`define CSR_CYCLEH          12'hC80
`define CSR_INSTRETH        12'hC82

// Identity registers read as zero
`define CSR_MVENDORID       12'hF11
`define CSR_MARCHID         12'hF12
`define CSR_MIMPID          12'hF13
`define CSR_MHARTID         12'hF14

`define CSR_MASK_MSTATUS    32'h0000_1888   // mpp, mpie, mie
`define CSR_MASK_MIE        32'h0000_0888   // meie, mtie, msie
`define CSR_MASK_ALIGN      32'hFFFF_FFFC
`define CSR_MASK_FULL       32'hFFFF_FFFF

`define CSR_MISA_VALUE      32'h4010_0100   // MXL=1, U, I

`define CSR_IRQ_SW          5'd3
`define CSR_IRQ_TIM         5'd7
`define CSR_IRQ_EXT         5'd11
`define CSR_EXC_ILLEGAL     5'd2

`endif

// ==== csr_pkg.sv ====
`include "csr_cfg.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0]   csr_data_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [4:0]             exc_code_t;

    // Encoded like the low bits of funct3 for CSRRW/CSRRS/CSRRC
    typedef enum logic [1:0] {
        WRITE = 2'b01,
        SET   = 2'b10,
        CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    typedef struct packed {
        logic      read_en;
        logic      write_en;
        csr_op_e   op;
        csr_addr_t addr;
        csr_data_t data;
    } csr_req_t;

    typedef struct packed {
        logic      exception;
        logic      mret;
        exc_code_t exc_code;
        csr_data_t pc;
        csr_data_t instr;        // Faulting instruction word
        logic      jump;
        csr_data_t jump_target;  // Next pc when a jump retires with the interrupt
    } trap_req_t;

endpackage

// ==== csr_read_mux.sv ====
`include "csr_cfg.svh"

module csr_read_mux (
    input  logic                     read_ok_i,
    input  csr_pkg::csr_addr_t       addr_i,
    input  csr_pkg::csr_data_t       mstatus_i,
    input  csr_pkg::csr_data_t       mie_i,
    input  csr_pkg::csr_data_t       mip_i,
    input  csr_pkg::csr_data_t       mtvec_i,
    input  csr_pkg::csr_data_t       mscratch_i,
    input  csr_pkg::csr_data_t       mepc_i,
    input  csr_pkg::csr_data_t       mcause_i,
    input  csr_pkg::csr_data_t       mtval_i,
    input  csr_pkg::csr_data_t [1:0] mcycle_i,    // [1] high word
    input  csr_pkg::csr_data_t [1:0] minstret_i,
    output csr_pkg::csr_data_t       cur_val_o,
    output csr_pkg::csr_data_t       read_data_o
);

    always_comb begin
        case (addr_i)
            `CSR_MSTATUS:               cur_val_o = mstatus_i;
            `CSR_MISA:                  cur_val_o = `CSR_MISA_VALUE;
            `CSR_MIE:                   cur_val_o = mie_i;
            `CSR_MTVEC:                 cur_val_o = mtvec_i;
            `CSR_MSCRATCH:              cur_val_o = mscratch_i;
            `CSR_MEPC:                  cur_val_o = mepc_i;
            `CSR_MCAUSE:                cur_val_o = mcause_i;
            `CSR_MTVAL:                 cur_val_o = mtval_i;
            `CSR_MIP:                   cur_val_o = mip_i;

            // Machine counters share their value with the user aliases
            `CSR_MCYCLE,    `CSR_CYCLE:    cur_val_o = mcycle_i[0];
            `CSR_MCYCLEH,   `CSR_CYCLEH:   cur_val_o = mcycle_i[1];
            `CSR_MINSTRET,  `CSR_INSTRET:  cur_val_o = minstret_i[0];
            `CSR_MINSTRETH, `CSR_INSTRETH: cur_val_o = minstret_i[1];

            `CSR_MVENDORID,
            `CSR_MARCHID,
            `CSR_MIMPID,
            `CSR_MHARTID:               cur_val_o = '0;
            default:                    cur_val_o = '0;   // Unknown address
        endcase
    end

    // Merge stage sees the ungated value, the core sees gated data
    assign read_data_o = read_ok_i ? cur_val_o : '0;

endmodule

// ==== csr_write_merge.sv ====
`include "csr_cfg.svh"

module csr_write_merge (
    input  csr_pkg::csr_addr_t addr_i,
    input  csr_pkg::csr_op_e   op_i,
    input  csr_pkg::csr_data_t data_i,
    input  csr_pkg::csr_data_t cur_val_i,
    output csr_pkg::csr_data_t wr_data_o
);

    import csr_pkg::*;

    csr_data_t wmask;

    always_comb begin
        case (addr_i)
            `CSR_MSTATUS:            wmask = `CSR_MASK_MSTATUS;
            `CSR_MIE:                wmask = `CSR_MASK_MIE;
            `CSR_MTVEC, `CSR_MEPC:   wmask = `CSR_MASK_ALIGN;   // Word aligned
            `CSR_MSCRATCH,
            `CSR_MCAUSE,
            `CSR_MTVAL,
            `CSR_MCYCLE,
            `CSR_MCYCLEH,
            `CSR_MINSTRET,
            `CSR_MINSTRETH:          wmask = `CSR_MASK_FULL;
            default:                 wmask = '0;   // misa, mip, aliases, ids
        endcase
    end

    always_comb begin
        case (op_i)
            WRITE:   wr_data_o = (cur_val_i & ~wmask) | (data_i & wmask);
            SET:     wr_data_o = cur_val_i | (data_i & wmask);
            CLEAR:   wr_data_o = cur_val_i & ~(data_i & wmask);
            default: wr_data_o = cur_val_i;
        endcase
    end

endmodule

// ==== csr_machine_regs.sv ====
`include "csr_cfg.svh"

module csr_machine_regs (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                write_ok_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::csr_data_t  wr_data_i,
    input  csr_pkg::trap_req_t  trap_i,
    input  logic                interrupt_ack_i,
    input  csr_pkg::exc_code_t  irq_code_i,
    output csr_pkg::csr_data_t  mstatus_o,
    output csr_pkg::csr_data_t  mie_o,
    output csr_pkg::csr_data_t  mtvec_o,
    output csr_pkg::csr_data_t  mscratch_o,
    output csr_pkg::csr_data_t  mepc_o,
    output csr_pkg::csr_data_t  mcause_o,
    output csr_pkg::csr_data_t  mtval_o,
    output csr_pkg::priv_e      priv_o
);

    import csr_pkg::*;

    logic      mstatus_mie;
    logic      mstatus_mpie;
    priv_e     mstatus_mpp;
    csr_data_t trap_mtval;

    // Only mie, mpie and mpp exist in mstatus
    assign mstatus_o = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};

    assign trap_mtval = (trap_i.exc_code == `CSR_EXC_ILLEGAL) ? trap_i.instr : trap_i.pc;

    ////////////////////////////////////////////////////////////////////////////
    // mret first, then exception, interrupt and CSR write
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_USER;
            mie_o        <= '0;
            mtvec_o      <= '0;
            mscratch_o   <= '0;
            mepc_o       <= '0;
            mcause_o     <= '0;
            mtval_o      <= '0;
            priv_o       <= PRIV_MACHINE;
        end else if (trap_i.mret) begin
            mstatus_mie <= mstatus_mpie;
            priv_o      <= mstatus_mpp;
        end else if (trap_i.exception || interrupt_ack_i) begin
            // Common trap entry
            mstatus_mpp  <= priv_o;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            priv_o       <= PRIV_MACHINE;
            mtval_o      <= trap_mtval;
            if (trap_i.exception) begin
                mepc_o   <= trap_i.pc;
                mcause_o <= {1'b0, 26'b0, trap_i.exc_code};
            end else begin
                // Current instruction retires, so return to the one after it
                mepc_o   <= trap_i.jump ? trap_i.jump_target : trap_i.pc + 32'd4;
                mcause_o <= {1'b1, 26'b0, irq_code_i};
            end
        end else if (write_ok_i) begin
            case (addr_i)
                `CSR_MSTATUS: begin
                    mstatus_mpp  <= priv_e'(wr_data_i[12:11]);
                    mstatus_mpie <= wr_data_i[7];
                    mstatus_mie  <= wr_data_i[3];
                end
                `CSR_MIE:      mie_o      <= wr_data_i;
                `CSR_MTVEC:    mtvec_o    <= wr_data_i;
                `CSR_MSCRATCH: mscratch_o <= wr_data_i;
                `CSR_MEPC:     mepc_o     <= wr_data_i;
                `CSR_MCAUSE:   mcause_o   <= wr_data_i;
                `CSR_MTVAL:    mtval_o    <= wr_data_i;
                default: ;   // Not held here
            endcase
        end
    end

endmodule

// ==== csr_counters.sv ====
`include "csr_cfg.svh"

module csr_counters (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     write_ok_i,
    input  csr_pkg::csr_addr_t       addr_i,
    input  csr_pkg::csr_data_t       wr_data_i,
    input  logic                     retire_i,
    output csr_pkg::csr_data_t [1:0] mcycle_o,
    output csr_pkg::csr_data_t [1:0] minstret_o
);

    import csr_pkg::*;

    // Half-word write wins over the increment
    function automatic logic [63:0] count_next(
        input logic [63:0] cur,
        input csr_addr_t   lo_addr,
        input csr_addr_t   hi_addr,
        input logic        inc
    );
        logic [63:0] nxt;
        if (write_ok_i && addr_i == lo_addr)
            nxt = {cur[63:32], wr_data_i};
        else if (write_ok_i && addr_i == hi_addr)
            nxt = {wr_data_i, cur[31:0]};
        else
            nxt = inc ? cur + 64'd1 : cur;
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= count_next(mcycle_o, `CSR_MCYCLE, `CSR_MCYCLEH, 1'b1);
            minstret_o <= count_next(minstret_o, `CSR_MINSTRET, `CSR_MINSTRETH, retire_i);
        end
    end

endmodule

// ==== csr_irq_ctrl.sv ====
`include "csr_cfg.svh"

module csr_irq_ctrl (
    input  logic               clk,
    input  logic               reset_n,
    input  csr_pkg::csr_data_t irq_i,
    input  csr_pkg::csr_data_t mie_i,
    input  logic               global_mie_i,
    input  logic               interrupt_ack_i,
    output csr_pkg::csr_data_t mip_o,
    output logic               interrupt_pending_o,
    output csr_pkg::exc_code_t irq_code_o
);

    logic take_irq;

    // Pending is dropped for the cycle after an acknowledge
    assign take_irq = global_mie_i && ((mie_i & mip_o) != '0) && !interrupt_ack_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            mip_o <= '0;
        else
            mip_o <= irq_i;   // Raw line sample
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            interrupt_pending_o <= 1'b0;
            irq_code_o          <= '0;
        end else begin
            interrupt_pending_o <= take_irq;
            if (take_irq) begin
                if (mip_o[11] && mie_i[11])         // External first
                    irq_code_o <= `CSR_IRQ_EXT;
                else if (mip_o[3] && mie_i[3])      // Then software
                    irq_code_o <= `CSR_IRQ_SW;
                else if (mip_o[7] && mie_i[7])
                    irq_code_o <= `CSR_IRQ_TIM;
            end
        end
    end

endmodule

// ==== csr_bank.sv ====
module csr_bank (
    input  logic               clk,
    input  logic               reset_n,
    input  csr_pkg::csr_req_t  csr_req_i,
    input  csr_pkg::trap_req_t trap_req_i,
    input  logic               killed_i,
    input  logic               hold_i,
    input  csr_pkg::csr_data_t irq_i,
    input  logic               interrupt_ack_i,
    output csr_pkg::csr_data_t read_data_o,
    output csr_pkg::priv_e     priv_o,
    output csr_pkg::csr_data_t mepc_o,
    output csr_pkg::csr_data_t mtvec_o,
    output logic               interrupt_pending_o
);

    import csr_pkg::*;

    logic            read_ok, write_ok, retire;
    csr_data_t       cur_val, wr_data;
    csr_data_t       mstatus, mie, mip, mscratch, mcause, mtval;
    csr_data_t [1:0] mcycle, minstret;
    exc_code_t       irq_code;

    ////////////////////////////////////////////////////////////////////////////
    // Killed instructions neither access CSRs nor retire
    ////////////////////////////////////////////////////////////////////////////

    assign read_ok  = csr_req_i.read_en & ~killed_i;
    assign write_ok = csr_req_i.write_en & ~killed_i;
    assign retire   = ~killed_i & ~hold_i;

    csr_read_mux i_read_mux (
        .read_ok_i   (read_ok),
        .addr_i      (csr_req_i.addr),
        .mstatus_i   (mstatus),
        .mie_i       (mie),
        .mip_i       (mip),
        .mtvec_i     (mtvec_o),
        .mscratch_i  (mscratch),
        .mepc_i      (mepc_o),
        .mcause_i    (mcause),
        .mtval_i     (mtval),
        .mcycle_i    (mcycle),
        .minstret_i  (minstret),
        .cur_val_o   (cur_val),
        .read_data_o (read_data_o)
    );

    csr_write_merge i_write_merge (
        .addr_i    (csr_req_i.addr),
        .op_i      (csr_req_i.op),
        .data_i    (csr_req_i.data),
        .cur_val_i (cur_val),
        .wr_data_o (wr_data)
    );

    csr_machine_regs i_machine_regs (
        .clk             (clk),
        .reset_n         (reset_n),
        .write_ok_i      (write_ok),
        .addr_i          (csr_req_i.addr),
        .wr_data_i       (wr_data),
        .trap_i          (trap_req_i),
        .interrupt_ack_i (interrupt_ack_i),
        .irq_code_i      (irq_code),
        .mstatus_o       (mstatus),
        .mie_o           (mie),
        .mtvec_o         (mtvec_o),
        .mscratch_o      (mscratch),
        .mepc_o          (mepc_o),
        .mcause_o        (mcause),
        .mtval_o         (mtval),
        .priv_o          (priv_o)
    );

    csr_counters i_counters (
        .clk        (clk),
        .reset_n    (reset_n),
        .write_ok_i (write_ok),
        .addr_i     (csr_req_i.addr),
        .wr_data_i  (wr_data),
        .retire_i   (retire),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    csr_irq_ctrl i_irq_ctrl (
        .clk                 (clk),
        .reset_n             (reset_n),
        .irq_i               (irq_i),
        .mie_i               (mie),
        .global_mie_i        (mstatus[3]),   // mstatus.mie
        .interrupt_ack_i     (interrupt_ack_i),
        .mip_o               (mip),
        .interrupt_pending_o (interrupt_pending_o),
        .irq_code_o          (irq_code)
    );

endmodule

// ==== csr_assertions.sv ====
module csr_assertions (
    input logic               clk,
    input logic               reset_n,
    input logic               killed_i,
    input logic               interrupt_ack_i,
    input csr_pkg::csr_data_t read_data_o,
    input csr_pkg::priv_e     priv_o,
    input logic               interrupt_pending_o
);

    timeunit 1ns;
    timeprecision 100ps;

    ack_clears_pending: assert property (
        @(posedge clk) disable iff (!reset_n)
        interrupt_ack_i |=> !interrupt_pending_o
    ) else $error("interrupt_pending_o high in the cycle after interrupt_ack_i");

    // Killed accesses never return data
    killed_reads_zero: assert property (
        @(posedge clk) disable iff (!reset_n)
        killed_i |-> read_data_o == '0
    ) else $error("read_data_o nonzero while killed_i is high");

    priv_known: assert property (
        @(posedge clk) disable iff (!reset_n)
        !$isunknown(priv_o)
    ) else $error("priv_o unknown after reset");

endmodule

bind csr_bank csr_assertions i_csr_assertions (
    .clk                 (clk),
    .reset_n             (reset_n),
    .killed_i            (killed_i),
    .interrupt_ack_i     (interrupt_ack_i),
    .read_data_o         (read_data_o),
    .priv_o              (priv_o),
    .interrupt_pending_o (interrupt_pending_o)
);

// ==== tb_csr_bank.sv ====
`include "csr_cfg.svh"

module tb_csr_bank;

    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;

    localparam int TEST_CYCLES    = 200;               // Rough sum over all tests
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    localparam csr_req_t  REQ_IDLE  = '{read_en: 1'b0, write_en: 1'b0, op: WRITE,
                                        addr: '0, data: '0};
    localparam trap_req_t TRAP_IDLE = '{exception: 1'b0, mret: 1'b0, exc_code: '0,
                                        pc: '0, instr: '0, jump: 1'b0, jump_target: '0};

    logic      clk;
    logic      reset_n;
    csr_req_t  csr_req_i;
    trap_req_t trap_req_i;
    logic      killed_i;
    logic      hold_i;
    csr_data_t irq_i;
    logic      interrupt_ack_i;
    csr_data_t read_data_o;
    priv_e     priv_o;
    csr_data_t mepc_o;
    csr_data_t mtvec_o;
    logic      interrupt_pending_o;

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          check_count;
    int          error_count;
    csr_data_t   scratch_expected;   // mscratch as the tests expect it

    csr_bank i_csr_bank (
        .clk                 (clk),
        .reset_n             (reset_n),
        .csr_req_i           (csr_req_i),
        .trap_req_i          (trap_req_i),
        .killed_i            (killed_i),
        .hold_i              (hold_i),
        .irq_i               (irq_i),
        .interrupt_ack_i     (interrupt_ack_i),
        .read_data_o         (read_data_o),
        .priv_o              (priv_o),
        .mepc_o              (mepc_o),
        .mtvec_o             (mtvec_o),
        .interrupt_pending_o (interrupt_pending_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return value;
    endfunction

    task automatic check_value(input string name, input csr_data_t actual,
                               input csr_data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d error(s)", name, error_count - errors_before);
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_op_e op, input csr_data_t data);
        @(posedge clk);
        csr_req_i <= '{read_en: 1'b0, write_en: 1'b1, op: op, addr: addr, data: data};
        @(posedge clk);
        csr_req_i <= REQ_IDLE;                   // Write lands on this edge
    endtask

    // Read data is combinational and sampled mid-cycle
    task automatic read_csr(input csr_addr_t addr, output csr_data_t data);
        @(posedge clk);
        csr_req_i <= '{read_en: 1'b1, write_en: 1'b0, op: WRITE, addr: addr, data: '0};
        @(negedge clk);
        data = read_data_o;
    endtask

    task automatic apply_trap(input trap_req_t trap, input csr_req_t req);
        @(posedge clk);
        trap_req_i <= trap;
        csr_req_i  <= req;
        @(posedge clk);
        trap_req_i <= TRAP_IDLE;
        csr_req_i  <= REQ_IDLE;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        csr_addr_t id_addr [4];
        csr_data_t rd;
        int        errors_before;
        errors_before = error_count;
        id_addr = '{`CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID};
        read_csr(`CSR_MISA, rd);
        check_value("read_data_o (misa)", rd, `CSR_MISA_VALUE);
        read_csr(`CSR_MSTATUS, rd);
        check_value("read_data_o (mstatus)", rd, '0);
        read_csr(`CSR_MEPC, rd);
        check_value("read_data_o (mepc)", rd, '0);
        read_csr(`CSR_MCAUSE, rd);
        check_value("read_data_o (mcause)", rd, '0);
        foreach (id_addr[i]) begin
            read_csr(id_addr[i], rd);
            check_value("read_data_o (identity)", rd, '0);
        end
        check_value("priv_o", 32'(priv_o), 32'(PRIV_MACHINE));
        check_value("interrupt_pending_o", 32'(interrupt_pending_o), '0);
        report_test("reset_state", errors_before);
    endtask

    task automatic test_write_set_clear();
        csr_data_t data;
        csr_data_t rd;
        int        errors_before;
        errors_before = error_count;
        data = random_bits(32);
        write_csr(`CSR_MSCRATCH, WRITE, data);
        scratch_expected = data;
        read_csr(`CSR_MSCRATCH, rd);
        check_value("read_data_o (mscratch write)", rd, scratch_expected);
        data = random_bits(32);
        write_csr(`CSR_MSCRATCH, SET, data);
        scratch_expected = scratch_expected | data;
        read_csr(`CSR_MSCRATCH, rd);
        check_value("read_data_o (mscratch set)", rd, scratch_expected);
        data = random_bits(32);
        write_csr(`CSR_MSCRATCH, CLEAR, data);
        scratch_expected = scratch_expected & ~data;
        read_csr(`CSR_MSCRATCH, rd);
        check_value("read_data_o (mscratch clear)", rd, scratch_expected);

        // mtvec keeps only a word address
        data = (random_bits(30) << 2) | 32'd3;           // Low bits set so the drop shows
        write_csr(`CSR_MTVEC, WRITE, data);
        read_csr(`CSR_MTVEC, rd);
        check_value("read_data_o (mtvec)", rd, {data[31:2], 2'b00});
        check_value("mtvec_o", mtvec_o, {data[31:2], 2'b00});

        @(posedge clk);
        csr_req_i <= '{read_en: 1'b1, write_en: 1'b1, op: WRITE, addr: `CSR_MSCRATCH,
                       data: ~scratch_expected};
        killed_i  <= 1'b1;
        @(negedge clk);
        check_value("read_data_o (killed)", read_data_o, '0);
        @(posedge clk);
        csr_req_i <= REQ_IDLE;
        killed_i  <= 1'b0;
        read_csr(`CSR_MSCRATCH, rd);
        check_value("read_data_o (mscratch after kill)", rd, scratch_expected);
        report_test("write_set_clear", errors_before);
    endtask

    task automatic test_trap_and_return();
        trap_req_t trap;
        csr_req_t  req;
        csr_data_t pc;
        csr_data_t instr;
        csr_data_t rd;
        int        errors_before;
        errors_before = error_count;
        write_csr(`CSR_MSTATUS, SET, 32'h0000_0008);     // mstatus.mie
        pc    = random_bits(30) << 2;
        instr = random_bits(32);
        trap  = '{exception: 1'b1, mret: 1'b0, exc_code: `CSR_EXC_ILLEGAL, pc: pc,
                  instr: instr, jump: 1'b0, jump_target: '0};
        req   = '{read_en: 1'b0, write_en: 1'b1, op: WRITE, addr: `CSR_MSCRATCH,
                  data: ~scratch_expected};               // Loses to the trap
        apply_trap(trap, req);
        @(negedge clk);
        check_value("mepc_o", mepc_o, pc);
        check_value("priv_o", 32'(priv_o), 32'(PRIV_MACHINE));
        read_csr(`CSR_MCAUSE, rd);
        check_value("read_data_o (mcause)", rd, 32'(`CSR_EXC_ILLEGAL));
        read_csr(`CSR_MTVAL, rd);
        check_value("read_data_o (mtval)", rd, instr);
        read_csr(`CSR_MSTATUS, rd);
        check_value("read_data_o (mstatus)", rd, 32'h0000_1880);   // mpp=M, mpie=1, mie=0
        read_csr(`CSR_MSCRATCH, rd);
        check_value("read_data_o (mscratch)", rd, scratch_expected);

        trap      = TRAP_IDLE;
        trap.mret = 1'b1;
        apply_trap(trap, REQ_IDLE);
        read_csr(`CSR_MSTATUS, rd);
        check_value("mstatus.mie", 32'(rd[3]), 32'd1);

        // Any other cause records the pc in mtval
        pc    = random_bits(30) << 2;
        instr = random_bits(32);
        trap  = '{exception: 1'b1, mret: 1'b0, exc_code: 5'd5, pc: pc,
                  instr: instr, jump: 1'b0, jump_target: '0};
        apply_trap(trap, REQ_IDLE);
        read_csr(`CSR_MTVAL, rd);
        check_value("read_data_o (mtval)", rd, pc);
        read_csr(`CSR_MCAUSE, rd);
        check_value("read_data_o (mcause)", rd, 32'd5);
        report_test("trap_and_return", errors_before);
    endtask

    task automatic take_interrupt(input logic jump, input csr_data_t target);
        csr_data_t pc;
        csr_data_t rd;
        logic      seen;
        pc = random_bits(30) << 2;
        write_csr(`CSR_MSTATUS, SET, 32'h0000_0008);
        @(posedge clk);
        irq_i <= 32'h0000_0808;                          // External and software lines
        seen = 1'b0;
        for (int i = 0; i < 4 && !seen; i++) begin
            @(negedge clk);
            seen = interrupt_pending_o;
        end
        if (!seen) begin
            error_count++;
            $display("interrupt_pending_o did not rise within 4 cycles of irq_i");
        end
        @(posedge clk);
        interrupt_ack_i <= 1'b1;
        irq_i           <= '0;
        trap_req_i      <= '{exception: 1'b0, mret: 1'b0, exc_code: '0, pc: pc,
                             instr: '0, jump: jump, jump_target: target};
        @(posedge clk);
        interrupt_ack_i <= 1'b0;
        trap_req_i      <= TRAP_IDLE;
        @(negedge clk);
        check_value("interrupt_pending_o", 32'(interrupt_pending_o), '0);
        check_value("mepc_o", mepc_o, jump ? target : pc + 32'd4);
        read_csr(`CSR_MCAUSE, rd);
        check_value("read_data_o (mcause)", rd, {1'b1, 26'b0, `CSR_IRQ_EXT});
    endtask

    task automatic test_interrupts();
        int errors_before;
        errors_before = error_count;
        write_csr(`CSR_MIE, WRITE, 32'h0000_0808);       // msie and meie
        take_interrupt(1'b0, '0);
        take_interrupt(1'b1, random_bits(30) << 2);
        report_test("interrupts", errors_before);
    endtask

    task automatic test_counters();
        csr_data_t first;
        csr_data_t second;
        csr_data_t high;
        csr_data_t rd;
        int        errors_before;
        errors_before = error_count;
        read_csr(`CSR_MCYCLE, first);
        repeat (9) @(posedge clk);
        read_csr(`CSR_MCYCLE, second);                   // Ten edges later
        check_value("mcycle delta", second - first, 32'd10);

        @(posedge clk);
        hold_i <= 1'b1;
        read_csr(`CSR_MINSTRET, first);
        repeat (5) @(posedge clk);
        read_csr(`CSR_MINSTRET, second);
        check_value("minstret delta (hold)", second - first, '0);
        @(posedge clk);
        hold_i <= 1'b0;
        read_csr(`CSR_MINSTRET, first);
        read_csr(`CSR_MINSTRET, second);
        check_value("minstret delta (running)", second - first, 32'd1);

        high = random_bits(32);
        write_csr(`CSR_MCYCLEH, WRITE, high);
        read_csr(`CSR_MCYCLEH, rd);
        check_value("read_data_o (mcycleh)", rd, high);
        read_csr(`CSR_CYCLEH, rd);
        check_value("read_data_o (cycleh)", rd, high);
        report_test("counters", errors_before);
    endtask

    initial begin
        clk              = 1'b0;
        reset_n          = 1'b0;
        csr_req_i        = REQ_IDLE;
        trap_req_i       = TRAP_IDLE;
        killed_i         = 1'b0;
        hold_i           = 1'b0;
        irq_i            = '0;
        interrupt_ack_i  = 1'b0;
        lfsr_state       = 32'd51;
        cycle_count      = 0;
        check_count      = 0;
        error_count      = 0;
        scratch_expected = '0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_state();
        test_write_set_clear();
        test_trap_and_return();
        test_interrupts();
        test_counters();

        $display("Tests: 5, checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
csr_pkg.sv
csr_read_mux.sv
csr_write_merge.sv
csr_machine_regs.sv
csr_counters.sv
csr_irq_ctrl.sv
csr_bank.sv
csr_assertions.sv
tb_csr_bank.sv

// ==== Makefile ====
TOP = tb_csr_bank

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
